//--- design/line_pkg.sv
// shared widths and step codes for the line generator
// coordinates are signed two's complement, so lines may cross the origin
// err_w leaves room for deltas up to 4095 and for doubling the error

package line_pkg;

  // signed pixel coordinate
  localparam int coord_w = 12;

  // signed error term, two extra bits over a coordinate
  localparam int err_w = coord_w + 2;

  // per-axis step direction
  localparam logic [1:0] dir_zero = 2'b00; // hold
  localparam logic [1:0] dir_pos  = 2'b01; // increment
  localparam logic [1:0] dir_neg  = 2'b11; // decrement

endpackage

//--- design/line_params_if.sv
// geometry of the line being drawn, latched once per line
// dx is the absolute x distance, dy the negated absolute y distance
// members only change in the cycle a line is loaded

`timescale 1ns/1ns

interface line_params_if;

  logic [1:0]                         x_dir; // step code for x
  logic [1:0]                         y_dir; // step code for y
  logic signed [line_pkg::err_w-1:0]   dx;    // |b_x - a_x|, never negative
  logic signed [line_pkg::err_w-1:0]   dy;    // -|b_y - a_y|, never positive
  logic signed [line_pkg::coord_w-1:0] end_x; // last pixel x
  logic signed [line_pkg::coord_w-1:0] end_y; // last pixel y

  // setup side owns every member
  modport setup (
    output x_dir,
    output y_dir,
    output dx,
    output dy,
    output end_x,
    output end_y
  );

  // stepper only looks
  modport stepper (
    input x_dir,
    input y_dir,
    input dx,
    input dy,
    input end_x,
    input end_y
  );

endinterface

//--- design/line_setup.sv
// latches line geometry on load, straight from the live end points
// init_err is combinational from the inputs so the stepper can seed its
// error in the load cycle, and it is only meaningful while load is high

`timescale 1ns/1ns

module line_setup (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                load,     // one cycle, line accepted
  input  logic signed [line_pkg::coord_w-1:0] a_x,      // start point
  input  logic signed [line_pkg::coord_w-1:0] a_y,
  input  logic signed [line_pkg::coord_w-1:0] b_x,      // end point
  input  logic signed [line_pkg::coord_w-1:0] b_y,
  line_params_if.setup                        params,
  output logic signed [line_pkg::err_w-1:0]   init_err  // dx + dy of the live inputs
);

  logic signed [line_pkg::err_w-1:0] diff_x; // b - a, widened before subtracting
  logic signed [line_pkg::err_w-1:0] diff_y;
  logic signed [line_pkg::err_w-1:0] dx_next; // absolute x distance
  logic signed [line_pkg::err_w-1:0] dy_next; // negated absolute y distance

  // step code from the sign of a difference
  function automatic logic [1:0] dir_of(input logic signed [line_pkg::err_w-1:0] diff);
    if (diff < 0)
      dir_of = line_pkg::dir_neg;
    else if (diff == 0)
      dir_of = line_pkg::dir_zero;
    else
      dir_of = line_pkg::dir_pos;
  endfunction

  assign diff_x = b_x - a_x; // signed operands extend to err_w here
  assign diff_y = b_y - a_y;

  assign dx_next  = diff_x[line_pkg::err_w-1] ? -diff_x : diff_x;
  assign dy_next  = diff_y[line_pkg::err_w-1] ? diff_y : -diff_y; // always <= 0
  assign init_err = dx_next + dy_next; // bresenham starting error

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      params.x_dir <= line_pkg::dir_zero;
      params.y_dir <= line_pkg::dir_zero;
      params.dx    <= '0;
      params.dy    <= '0;
      params.end_x <= '0;
      params.end_y <= '0;
    end else if (load) begin
      params.x_dir <= dir_of(diff_x); // which way x walks
      params.y_dir <= dir_of(diff_y);
      params.dx    <= dx_next;
      params.dy    <= dy_next;
      params.end_x <= b_x;            // stepper stops here
      params.end_y <= b_y;
    end
  end

  // the stepper's comparisons rely on these signs for termination
  sign_check: assert property (
    @(posedge clk) disable iff (reset)
    !params.dx[line_pkg::err_w-1] && (params.dy <= 0)
  ) else $error("line_setup: dx negative or dy positive");

endmodule

//--- design/line_stepper.sv
// walks the current pixel one bresenham step per advance
// load and advance never come together, load wins if they did
// e2 is one bit wider than the error so doubling cannot overflow

`timescale 1ns/1ns

module line_stepper (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                load,     // take start point and init_err
  input  logic                                advance,  // take one step this cycle
  input  logic signed [line_pkg::coord_w-1:0] a_x,      // start point
  input  logic signed [line_pkg::coord_w-1:0] a_y,
  input  logic signed [line_pkg::err_w-1:0]   init_err, // dx + dy from setup
  line_params_if.stepper                      params,
  output logic signed [line_pkg::coord_w-1:0] x_coord,  // current pixel
  output logic signed [line_pkg::coord_w-1:0] y_coord,
  output logic                                at_end    // current pixel is the last one
);

  logic signed [line_pkg::err_w-1:0] err;      // bresenham error term
  logic signed [line_pkg::err_w:0]   e2;       // twice the error
  logic                              step_x;   // x moves this step
  logic                              step_y;   // y moves this step
  logic signed [line_pkg::err_w-1:0] err_next; // error after this step
  logic signed [line_pkg::err_w-1:0] add_x;    // contribution of an x move
  logic signed [line_pkg::err_w-1:0] add_y;    // contribution of a y move

  // one pixel along an axis in the given direction
  function automatic logic signed [line_pkg::coord_w-1:0] move(
    input logic signed [line_pkg::coord_w-1:0] pos,
    input logic [1:0]                          dir
  );
    case (dir)
      line_pkg::dir_pos: move = pos + 1'b1;
      line_pkg::dir_neg: move = pos - 1'b1;
      default:           move = pos;        // axis does not move
    endcase
  endfunction

  assign e2 = {err, 1'b0}; // exact, no bits lost

  // both tests look at the old error
  assign step_x = (e2 >= params.dy);
  assign step_y = (e2 <= params.dx);

  always_comb begin
    add_x    = step_x ? params.dy : '0;
    add_y    = step_y ? params.dx : '0;
    err_next = err + add_x + add_y;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      x_coord <= '0;
      y_coord <= '0;
      err     <= '0;
    end else if (load) begin
      x_coord <= a_x;      // first pixel is the start point
      y_coord <= a_y;
      err     <= init_err;
    end else if (advance) begin
      err <= err_next;
      if (step_x)
        x_coord <= move(x_coord, params.x_dir);
      if (step_y)
        y_coord <= move(y_coord, params.y_dir);
    end
  end

  assign at_end = (x_coord == params.end_x) && (y_coord == params.end_y);

  // control must stop stepping once the end point is reached
  no_step_past_end: assert property (
    @(posedge clk) disable iff (reset)
    !(advance && at_end)
  ) else $error("line_stepper: advance while at end point");

endmodule

//--- design/line_control.sv
// idle/draw state for one line at a time
// run, enable and pause are plain levels, outputs are plain strobes
// a held run restarts a new line right after the last pixel

`timescale 1ns/1ns

module line_control (
  input  logic clk,
  input  logic reset,
  input  logic enable,        // low freezes the unit
  input  logic run,           // request a line, level
  input  logic pause,         // hold drawing, keeps place
  input  logic at_end,        // stepper sits on the end point
  output logic load,          // one cycle, line accepted
  output logic advance,       // step the stepper this cycle
  output logic busy,          // line pending or being drawn
  output logic pixel_valid,   // x/y coordinate is a pixel
  output logic line_complete  // this pixel is the last one
);

  logic draw;   // registered draw state
  logic active; // draw cycle that is neither frozen nor paused

  assign active = draw && enable && !pause;

  // accept only from idle, run while busy is dropped
  assign load = !draw && run && enable && !pause;

  assign pixel_valid   = active;            // forced low by pause or enable
  assign advance       = active && !at_end; // step unless this is the last pixel
  assign line_complete = active && at_end;
  assign busy          = draw || run;       // high already in the accept cycle

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      draw <= 1'b0;
    end else if (load) begin
      draw <= 1'b1;   // first pixel next cycle
    end else if (line_complete) begin
      draw <= 1'b0;   // back to idle after the last pixel
    end
  end

  // the last pixel is always a real pixel
  complete_is_pixel: assert property (
    @(posedge clk) disable iff (reset)
    line_complete |-> pixel_valid
  ) else $error("line_control: line_complete without pixel_valid");

  // pixels only appear while the parent sees the unit busy
  pixel_in_busy: assert property (
    @(posedge clk) disable iff (reset)
    pixel_valid |-> busy
  ) else $error("line_control: pixel_valid while not busy");

endmodule

//--- design/line_generator.sv
// bresenham line generator, one pixel per enabled unpaused cycle
// end points are sampled only in the cycle run is accepted
// the first pixel shows the cycle after acceptance, the last one carries
// line_complete, and equal end points give a single pixel

`timescale 1ns/1ns

module line_generator (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                enable,        // low freezes the unit
  input  logic                                run,           // start a line
  input  logic                                pause,         // hold drawing
  input  logic signed [line_pkg::coord_w-1:0] a_x,           // start point
  input  logic signed [line_pkg::coord_w-1:0] a_y,
  input  logic signed [line_pkg::coord_w-1:0] b_x,           // end point
  input  logic signed [line_pkg::coord_w-1:0] b_y,
  output logic                                busy,          // running or run raised
  output logic                                pixel_valid,   // coordinate is a pixel
  output logic                                line_complete, // last pixel of the line
  output logic signed [line_pkg::coord_w-1:0] x_coord,       // current pixel
  output logic signed [line_pkg::coord_w-1:0] y_coord
);

  logic                              load;     // line accepted this cycle
  logic                              advance;  // step this cycle
  logic                              at_end;   // on the end point
  logic signed [line_pkg::err_w-1:0] init_err; // starting error for the stepper

  line_params_if params (); // latched geometry, setup to stepper

  line_setup u_setup (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .a_x      (a_x),
    .a_y      (a_y),
    .b_x      (b_x),
    .b_y      (b_y),
    .params   (params.setup),
    .init_err (init_err)
  );

  line_stepper u_stepper (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .advance  (advance),
    .a_x      (a_x),
    .a_y      (a_y),
    .init_err (init_err),
    .params   (params.stepper),
    .x_coord  (x_coord),
    .y_coord  (y_coord),
    .at_end   (at_end)
  );

  line_control u_control (
    .clk           (clk),
    .reset         (reset),
    .enable        (enable),
    .run           (run),
    .pause         (pause),
    .at_end        (at_end),
    .load          (load),
    .advance       (advance),
    .busy          (busy),
    .pixel_valid   (pixel_valid),
    .line_complete (line_complete)
  );

endmodule

//--- tb/tb_clock.sv
// free-running clock of 8 ns and a power-on reset held for two cycles
// reset is released on a falling edge, away from the sampling edge

`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  initial begin
    reset = 1'b1;            // asserted from time zero
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

//--- tb/tb_line_generator.sv
// random lines against a bresenham model, one pixel list per line
// inputs change on the falling edge, outputs are sampled 2 ns later
// every draw loop has a cycle limit, a timeout skips the rest of the run

`timescale 1ns/1ns

module tb_line_generator;

  localparam int num_lines = 200; // random lines after the directed ones

  logic                                clk;
  logic                                reset;
  logic                                enable;
  logic                                run;
  logic                                pause;
  logic signed [line_pkg::coord_w-1:0] a_x;
  logic signed [line_pkg::coord_w-1:0] a_y;
  logic signed [line_pkg::coord_w-1:0] b_x;
  logic signed [line_pkg::coord_w-1:0] b_y;
  logic                                busy;
  logic                                pixel_valid;
  logic                                line_complete;
  logic signed [line_pkg::coord_w-1:0] x_coord;
  logic signed [line_pkg::coord_w-1:0] y_coord;

  integer seed = 5;   // fixed, runs repeat exactly
  int     checks;
  int     errors;
  int     timeouts;
  bit     timed_out;  // set once, the remaining steps are skipped
  int     exp_x[$];   // expected pixels of the current line
  int     exp_y[$];

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  line_generator dut (
    .clk           (clk),
    .reset         (reset),
    .enable        (enable),
    .run           (run),
    .pause         (pause),
    .a_x           (a_x),
    .a_y           (a_y),
    .b_x           (b_x),
    .b_y           (b_y),
    .busy          (busy),
    .pixel_valid   (pixel_valid),
    .line_complete (line_complete),
    .x_coord       (x_coord),
    .y_coord       (y_coord)
  );

  function automatic int small_coord();
    small_coord = $random(seed) % 65; // -64 .. 64
  endfunction

  function automatic int wide_coord();
    wide_coord = $random(seed) % 2048; // nearly the whole signed range
  endfunction

  // one cycle: drive on the falling edge, settle, then outputs are readable
  task automatic step_cycle(input logic r, input logic en, input logic ps,
                            input int ax, input int ay, input int bx, input int by);
    @(negedge clk);
    run    = r;
    enable = en;
    pause  = ps;
    a_x    = ax;
    a_y    = ay;
    b_x    = bx;
    b_y    = by;
    #2;
  endtask

  task automatic expect_bit(input string what, input logic got, input logic want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  task automatic expect_point(input string what, input int want_x, input int want_y);
    checks++;
    assert ((x_coord === want_x) && (y_coord === want_y)) else begin
      errors++;
      $display("[ERROR] %0t: %s is (%0d,%0d), expected (%0d,%0d)", $time, what,
               x_coord, y_coord, want_x, want_y);
    end
  endtask

  // reference pixel list, textbook bresenham with inclusive tests
  task automatic build_model(input int ax, input int ay, input int bx, input int by);
    int x;
    int y;
    int sx;
    int sy;
    int dx;
    int dy;
    int err;
    int e2;
    exp_x.delete();
    exp_y.delete();
    dx  = (bx > ax) ? bx - ax : ax - bx;
    dy  = (by > ay) ? ay - by : by - ay; // negative or zero
    sx  = (bx > ax) ? 1 : ((bx < ax) ? -1 : 0);
    sy  = (by > ay) ? 1 : ((by < ay) ? -1 : 0);
    err = dx + dy;
    x   = ax;
    y   = ay;
    exp_x.push_back(x);
    exp_y.push_back(y);
    while ((x != bx) || (y != by)) begin
      e2 = 2 * err;
      if (e2 >= dy) begin
        err += dy;
        x   += sx;
      end
      if (e2 <= dx) begin
        err += dx;
        y   += sy;
      end
      exp_x.push_back(x);
      exp_y.push_back(y);
    end
  endtask

  task automatic check_reset();
    int waited;
    @(negedge clk);
    #2;
    expect_bit("busy in reset", busy, 1'b0);
    expect_bit("pixel_valid in reset", pixel_valid, 1'b0);
    expect_bit("line_complete in reset", line_complete, 1'b0);
    expect_point("coordinate in reset", 0, 0);
    waited = 0;
    while ((reset !== 1'b0) && (waited < 10)) begin
      @(negedge clk);
      waited++;
    end
    if (reset !== 1'b0) begin
      timeouts++;
      timed_out = 1'b1;
      $display("timeout: reset was never released");
    end else begin
      step_cycle(1'b0, 1'b1, 1'b0, 0, 0, 0, 0);
      expect_bit("busy after reset", busy, 1'b0);
      expect_bit("pixel_valid after reset", pixel_valid, 1'b0);
      expect_bit("line_complete after reset", line_complete, 1'b0);
      expect_point("coordinate after reset", 0, 0);
    end
  endtask

  // run while disabled or paused must not start a line
  task automatic refused_run_check();
    int i;
    if (timed_out)
      return;
    for (i = 0; i < 3; i++) begin
      step_cycle(1'b1, i == 1, i != 0, small_coord(), small_coord(),
                 small_coord(), small_coord());
      expect_bit("busy follows run while idle", busy, 1'b1);
      expect_bit("pixel_valid with run refused", pixel_valid, 1'b0);
    end
    step_cycle(1'b0, 1'b1, 1'b0, 0, 0, 0, 0);
    expect_bit("busy after refused run", busy, 1'b0);
    expect_bit("pixel_valid after refused run", pixel_valid, 1'b0);
  endtask

  task automatic draw_line(input int ax, input int ay, input int bx, input int by,
                           input bit stalls);
    int   idx;
    int   cycles;
    int   n_stall;
    bit   done;
    logic r;
    logic en;
    logic ps;
    int   jx;
    int   jy;
    int   kx;
    int   ky;
    if (timed_out)
      return;
    build_model(ax, ay, bx, by);
    step_cycle(1'b1, 1'b1, 1'b0, ax, ay, bx, by); // acceptance, cycle 0
    expect_bit("busy in accept cycle", busy, 1'b1);
    expect_bit("pixel_valid in accept cycle", pixel_valid, 1'b0);
    idx     = 0;
    cycles  = 0;
    n_stall = 0;
    done    = 1'b0;
    while (!done && !timed_out) begin
      r  = 1'b0;
      en = 1'b1;
      ps = 1'b0;
      jx = ax;
      jy = ay;
      kx = bx;
      ky = by;
      if (stalls) begin
        ps = ({$random(seed)} % 4) == 0;
        en = ({$random(seed)} % 8) != 0;
        r  = ({$random(seed)} % 6) == 0; // run while busy, other end points
        if (r) begin
          jx = small_coord();
          jy = small_coord();
          kx = small_coord();
          ky = small_coord();
        end
      end
      step_cycle(r, en, ps, jx, jy, kx, ky);
      cycles++;
      expect_bit("busy while drawing", busy, 1'b1);
      expect_bit("pixel_valid", pixel_valid, en && !ps);
      if (pixel_valid === 1'b1) begin
        if (idx < exp_x.size()) begin
          expect_point($sformatf("pixel %0d", idx), exp_x[idx], exp_y[idx]);
          expect_bit("line_complete", line_complete, idx == exp_x.size() - 1);
        end else begin
          checks++;
          errors++;
          $display("[ERROR] %0t: pixel %0d is past the end of the line", $time, idx);
        end
        done = (line_complete === 1'b1);
        idx++;
      end else begin
        n_stall++;
        expect_bit("line_complete while stalled", line_complete, 1'b0);
      end
      if (!done && (cycles > exp_x.size() + n_stall + 8)) begin
        timeouts++;
        timed_out = 1'b1;
        $display("timeout: line (%0d,%0d) to (%0d,%0d) gave no line_complete in %0d cycles",
                 ax, ay, bx, by, cycles);
      end
    end
    if (!timed_out) begin
      step_cycle(1'b0, 1'b1, 1'b0, ax, ay, bx, by); // idle again
      expect_bit("busy after last pixel", busy, 1'b0);
      expect_bit("pixel_valid after last pixel", pixel_valid, 1'b0);
    end
  endtask

  // mix of horizontal, vertical, diagonal, single point and long lines
  task automatic pick_line(output int ax, output int ay, output int bx, output int by);
    int kind;
    int d;
    kind = {$random(seed)} % 16;
    ax   = small_coord();
    ay   = small_coord();
    bx   = small_coord();
    by   = small_coord();
    d    = small_coord();
    case (kind)
      0, 1: by = ay;              // horizontal
      2, 3: bx = ax;              // vertical
      4, 5: begin
        bx = ax + d;
        by = ({$random(seed)} % 2) ? ay + d : ay - d;
      end
      6: begin                    // single point
        bx = ax;
        by = ay;
      end
      7: begin
        ax = wide_coord();
        ay = wide_coord();
        bx = wide_coord();
        by = wide_coord();
      end
      default: ;                  // any octant, short
    endcase
  endtask

  initial begin
    int n;
    int ax;
    int ay;
    int bx;
    int by;
    run       = 1'b0;
    enable    = 1'b0;
    pause     = 1'b0;
    a_x       = '0;
    a_y       = '0;
    b_x       = '0;
    b_y       = '0;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    timed_out = 1'b0;
    check_reset();
    draw_line(5, -3, 5, -3, 1'b0);    // one pixel in cycle 1
    draw_line(-4, 2, 9, 2, 1'b0);
    draw_line(3, 7, 3, -6, 1'b0);
    draw_line(-5, -5, 5, 5, 1'b0);
    draw_line(10, 0, -2, 17, 1'b0);
    draw_line(0, 0, 7, -3, 1'b1);
    refused_run_check();
    for (n = 0; (n < num_lines) && !timed_out; n++) begin
      pick_line(ax, ay, bx, by);
      draw_line(ax, ay, bx, by, n % 2);
      if (n % 25 == 0)
        refused_run_check();
    end
    $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if ((errors == 0) && (timeouts == 0))
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- line_generator.f
design/line_pkg.sv
design/line_params_if.sv
design/line_setup.sv
design/line_stepper.sv
design/line_control.sv
design/line_generator.sv
tb/tb_clock.sv
tb/tb_line_generator.sv

//--- Bender.yml
package:
  name: line_generator

sources:
  - design/line_pkg.sv
  - design/line_params_if.sv
  - design/line_setup.sv
  - design/line_stepper.sv
  - design/line_control.sv
  - design/line_generator.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/tb_line_generator.sv
